//--- hdl/mem_geometry_pkg.sv
// Geometry constants of the shared byte memory port
// Address width, data width and default number of client channels

package mem_geometry_pkg;

   // Byte address width, 4 KiB of on-chip memory
   localparam int addr_width = 12;

   // One data item is a byte
   localparam int data_width = 8;

   // Three clients share the memory by default
   localparam int num_channels_default = 3;

endpackage

//--- hdl/mem_timing_pkg.sv
// Timing constants of one memory access
// Access length in cycles and the width of its counter

package mem_timing_pkg;

   // Cycles a single access keeps the arbiter busy
   localparam int access_cycles = 4;

   // Counter width, must hold access_cycles - 1
   localparam int count_width = 3;

endpackage

//--- hdl/channel_slot.sv
// Client request channel
// Holds one pending access and returns a ready pulse with read data

`timescale 1ns/10ps

module channel_slot #(
   parameter int addr_width = mem_geometry_pkg::addr_width,
   parameter int data_width = mem_geometry_pkg::data_width
) (
   input  logic                  clock_bus,
   input  logic                  rst_n,

   // Client side
   input  logic                  req,
   input  logic                  rnw,
   input  logic [addr_width-1:0] addr,
   input  logic [data_width-1:0] din,
   output logic                  ready,
   output logic [data_width-1:0] dout,

   // Arbiter side
   output logic                  pending,
   output logic                  pend_rnw,
   output logic [addr_width-1:0] pend_addr,
   output logic [data_width-1:0] pend_din,
   input  logic                  done,
   input  logic [data_width-1:0] rdata
);

   logic accept;

   // A request is only taken while the slot is free
   assign accept = req & ~pending;

   //========================================
   // Control state
   //========================================
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         pending <= 1'b0;
         ready   <= 1'b0;
      end else begin
         // Ready follows the arbiter's done by one cycle
         ready <= done;
         if (done) begin
            pending <= 1'b0;
         end else if (accept) begin
            pending <= 1'b1;
         end
      end
   end

   //========================================
   // Held request and returned data
   //========================================
   always_ff @(posedge clock_bus) begin
      if (accept) begin
         pend_rnw  <= rnw;
         pend_addr <= addr;
         pend_din  <= din;
      end
      // Writes leave dout untouched
      if (done && pend_rnw) begin
         dout <= rdata;
      end
   end

endmodule

//--- hdl/priority_arbiter.sv
// Fixed-priority arbiter over the client channels
// Picks the lowest pending index, runs the timed access to the byte memory
// and signals completion with a one-hot done vector and shared read data

`timescale 1ns/10ps

module priority_arbiter #(
   parameter int num_channels  = mem_geometry_pkg::num_channels_default,
   parameter int addr_width    = mem_geometry_pkg::addr_width,
   parameter int data_width    = mem_geometry_pkg::data_width,
   parameter int access_cycles = mem_timing_pkg::access_cycles
) (
   input  logic                             clock_bus,
   input  logic                             rst_n,

   // Channel slots
   input  logic [num_channels-1:0]          pending,
   input  logic [num_channels-1:0]          pend_rnw,
   input  logic [num_channels*addr_width-1:0] pend_addr,
   input  logic [num_channels*data_width-1:0] pend_din,
   output logic [num_channels-1:0]          done,
   output logic [data_width-1:0]            rdata,

   // Byte memory
   output logic                             mem_en,
   output logic                             mem_we,
   output logic [addr_width-1:0]            mem_addr,
   output logic [data_width-1:0]            mem_wdata,
   input  logic [data_width-1:0]            mem_rdata
);

   localparam int sel_width = (num_channels > 1) ? $clog2(num_channels) : 1;

   // FSM encoding
   localparam logic [1:0] st_idle    = 2'd0;
   localparam logic [1:0] st_access  = 2'd1;
   localparam logic [1:0] st_capture = 2'd2;
   localparam logic [1:0] st_finish  = 2'd3;

   localparam logic [mem_timing_pkg::count_width-1:0] last_count =
      mem_timing_pkg::count_width'(access_cycles - 1);

   logic [1:0]                         state;
   logic [mem_timing_pkg::count_width-1:0] count;
   logic [sel_width-1:0]               sel;
   logic [sel_width-1:0]               pick;
   logic                               any_pending;

   //========================================
   // Lowest pending index wins
   //========================================
   always_comb begin
      any_pending = 1'b0;
      pick        = '0;
      for (int i = num_channels - 1; i >= 0; i--) begin
         if (pending[i]) begin
            any_pending = 1'b1;
            pick        = sel_width'(i);
         end
      end
   end

   // Memory strobe on the last access cycle, fields from the chosen slot
   assign mem_en    = (state == st_access) && (count == last_count);
   assign mem_we    = mem_en & ~pend_rnw[sel];
   assign mem_addr  = pend_addr[sel*addr_width +: addr_width];
   assign mem_wdata = pend_din[sel*data_width +: data_width];

   //========================================
   // Access sequencing
   //========================================
   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         state <= st_idle;
         count <= '0;
         done  <= '0;
      end else begin
         case (state)
            st_idle: begin
               count <= '0;
               if (any_pending) begin
                  state <= st_access;
               end
            end
            st_access: begin
               if (count == last_count) begin
                  state <= st_capture;
               end else begin
                  count <= count + 1'b1;
               end
            end
            st_capture: begin
               // Read data arrives from the memory in this cycle
               done      <= '0;
               done[sel] <= 1'b1;
               state     <= st_finish;
            end
            default: begin
               // Slot drops pending at the end of this cycle
               done  <= '0;
               state <= st_idle;
            end
         endcase
      end
   end

   // Chosen index and read data
   always_ff @(posedge clock_bus) begin
      if (state == st_idle && any_pending) begin
         sel <= pick;
      end
      if (state == st_capture) begin
         rdata <= mem_rdata;
      end
   end

endmodule

//--- hdl/byte_ram.sv
// Synchronous byte-wide memory standing in for the SDRAM
// Registered read, one cycle after the enable

`timescale 1ns/10ps

module byte_ram #(
   parameter int addr_width = mem_geometry_pkg::addr_width,
   parameter int data_width = mem_geometry_pkg::data_width
) (
   input  logic                  clock_bus,
   input  logic                  mem_en,
   input  logic                  mem_we,
   input  logic [addr_width-1:0] mem_addr,
   input  logic [data_width-1:0] mem_wdata,
   output logic [data_width-1:0] mem_rdata
);

   localparam int depth = 1 << addr_width;

   logic [data_width-1:0] mem [0:depth-1];

   always_ff @(posedge clock_bus) begin
      if (mem_en) begin
         if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
         end else begin
            mem_rdata <= mem[mem_addr];
         end
      end
   end

endmodule

//--- hdl/mem_arbiter_top.sv
// Multi-channel byte memory port
// Channel slots per client, fixed-priority arbiter and the shared byte memory

`timescale 1ns/10ps

module mem_arbiter_top #(
   parameter int num_channels  = mem_geometry_pkg::num_channels_default,
   parameter int addr_width    = mem_geometry_pkg::addr_width,
   parameter int data_width    = mem_geometry_pkg::data_width,
   parameter int access_cycles = mem_timing_pkg::access_cycles
) (
   input  logic                               clock_bus,
   input  logic                               rst_n,
   input  logic [num_channels-1:0]            req,
   input  logic [num_channels-1:0]            rnw,
   input  logic [num_channels*addr_width-1:0] addr,
   input  logic [num_channels*data_width-1:0] din,
   output logic [num_channels-1:0]            ready,
   output logic [num_channels*data_width-1:0] dout
);

   // Slot to arbiter
   logic [num_channels-1:0]            pending;
   logic [num_channels-1:0]            pend_rnw;
   logic [num_channels*addr_width-1:0] pend_addr;
   logic [num_channels*data_width-1:0] pend_din;
   logic [num_channels-1:0]            done;
   logic [data_width-1:0]              rdata;

   // Arbiter to memory
   logic                               mem_en;
   logic                               mem_we;
   logic [addr_width-1:0]              mem_addr;
   logic [data_width-1:0]              mem_wdata;
   logic [data_width-1:0]              mem_rdata;

   //========================================
   // Client channels
   //========================================
   for (genvar g = 0; g < num_channels; g++) begin : g_slot
      channel_slot #(
         .addr_width (addr_width),
         .data_width (data_width)
      ) u_slot (
         .clock_bus (clock_bus),
         .rst_n     (rst_n),
         .req       (req[g]),
         .rnw       (rnw[g]),
         .addr      (addr[g*addr_width +: addr_width]),
         .din       (din[g*data_width +: data_width]),
         .ready     (ready[g]),
         .dout      (dout[g*data_width +: data_width]),
         .pending   (pending[g]),
         .pend_rnw  (pend_rnw[g]),
         .pend_addr (pend_addr[g*addr_width +: addr_width]),
         .pend_din  (pend_din[g*data_width +: data_width]),
         .done      (done[g]),
         .rdata     (rdata)
      );
   end

   //========================================
   // Arbiter and memory
   //========================================
   priority_arbiter #(
      .num_channels  (num_channels),
      .addr_width    (addr_width),
      .data_width    (data_width),
      .access_cycles (access_cycles)
   ) u_arbiter (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .pending   (pending),
      .pend_rnw  (pend_rnw),
      .pend_addr (pend_addr),
      .pend_din  (pend_din),
      .done      (done),
      .rdata     (rdata),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   byte_ram #(
      .addr_width (addr_width),
      .data_width (data_width)
   ) u_ram (
      .clock_bus (clock_bus),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule

//--- tb/mem_arbiter_tb.sv
// Testbench for the multi-channel byte memory port
// LFSR stimulus, shadow memory reference model, ready checker and timeout

`timescale 1ns/10ps

module mem_arbiter_tb;

   localparam int num_channels  = mem_geometry_pkg::num_channels_default;
   localparam int addr_width    = mem_geometry_pkg::addr_width;
   localparam int data_width    = mem_geometry_pkg::data_width;
   localparam int access_cycles = mem_timing_pkg::access_cycles;
   localparam int depth         = 1 << addr_width;

   // Request totals of the tests for the timeout
   localparam int traffic_per_channel = 60;
   localparam int total_requests = 32 + 16 + num_channels + traffic_per_channel * num_channels;
   localparam int timeout_cycles =
      total_requests * (num_channels + 1) * (access_cycles + 4) + 200;

   logic                               clock_bus = 1'b0;
   logic                               rst_n;
   logic [num_channels-1:0]            req;
   logic [num_channels-1:0]            rnw;
   logic [num_channels*addr_width-1:0] addr;
   logic [num_channels*data_width-1:0] din;
   logic [num_channels-1:0]            ready;
   logic [num_channels*data_width-1:0] dout;

   // Next input values applied on the rising edge
   logic [num_channels-1:0]            req_n  = '0;
   logic [num_channels-1:0]            rnw_n  = '0;
   logic [num_channels*addr_width-1:0] addr_n = '0;
   logic [num_channels*data_width-1:0] din_n  = '0;

   // Reference model and bookkeeping
   logic [data_width-1:0] shadow [0:depth-1];
   bit                    written [0:depth-1];
   int                    launch_cnt [num_channels] = '{default: 0};
   int                    done_cnt [num_channels] = '{default: 0};
   int                    remaining [num_channels];
   bit                    expect_read [num_channels];
   logic [data_width-1:0] expect_val [num_channels];
   int                    order_q [$];
   string                 test_name = "reset";
   logic [15:0]           lfsr_state = 16'd32834;
   int                    cycle_count = 0;

   mem_arbiter_top #(
      .num_channels  (num_channels),
      .addr_width    (addr_width),
      .data_width    (data_width),
      .access_cycles (access_cycles)
   ) u_dut (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .req       (req),
      .rnw       (rnw),
      .addr      (addr),
      .din       (din),
      .ready     (ready),
      .dout      (dout)
   );

   always #5 clock_bus = ~clock_bus;

   //========================================
   // Helpers
   //========================================
   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   // Taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[15]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   // Reference model returns the last byte the testbench wrote to this address
   function automatic logic [data_width-1:0] expected_byte(input logic [addr_width-1:0] a);
      return shadow[a];
   endfunction

   function automatic bit channel_busy(input int ch);
      return launch_cnt[ch] != done_cnt[ch];
   endfunction

   function automatic bit any_busy();
      bit b;
      b = 1'b0;
      for (int ch = 0; ch < num_channels; ch++) begin
         b = b | channel_busy(ch);
      end
      return b;
   endfunction

   task automatic push_inputs();
      req  <= req_n;
      rnw  <= rnw_n;
      addr <= addr_n;
      din  <= din_n;
      req_n = '0;
   endtask

   task automatic launch(input int ch, input bit rd, input logic [addr_width-1:0] a,
                         input logic [data_width-1:0] d);
      req_n[ch] = 1'b1;
      rnw_n[ch] = rd;
      addr_n[ch*addr_width +: addr_width] = a;
      din_n[ch*data_width +: data_width]  = d;
      expect_read[ch] = rd;
      if (rd) begin
         expect_val[ch] = expected_byte(a);
      end else begin
         shadow[a]  = d;
         written[a] = 1'b1;
      end
      launch_cnt[ch]++;
   endtask

   task automatic wait_free(input int ch);
      while (channel_busy(ch)) begin
         @(posedge clock_bus);
         push_inputs();
      end
   endtask

   task automatic wait_all_free();
      while (any_busy()) begin
         @(posedge clock_bus);
         push_inputs();
      end
   endtask

   // One access on one channel that returns once the channel is idle again
   task automatic access(input int ch, input bit rd, input logic [addr_width-1:0] a,
                         input logic [data_width-1:0] d);
      wait_free(ch);
      @(posedge clock_bus);
      launch(ch, rd, a, d);
      push_inputs();
      wait_free(ch);
   endtask

   // Random access inside the channel's own region (top two address bits)
   task automatic issue_random(input int ch);
      logic [addr_width-1:0] a;
      logic [data_width-1:0] d;
      bit                    rd;
      rd = take_bits(1) != 0;
      a  = addr_width'((ch << (addr_width - 2)) | take_bits(4));
      d  = data_width'(take_bits(data_width));
      // Unwritten bytes have no known value so they are written first
      if (!written[a]) begin
         rd = 1'b0;
      end
      launch(ch, rd, a, d);
   endtask

   //========================================
   // Checker and timeout
   //========================================
   always @(negedge clock_bus) begin
      if (rst_n) begin
         assert ($countones(ready) <= 1)
         else abort_run("two channels received ready in the same cycle");
         for (int ch = 0; ch < num_channels; ch++) begin
            if (ready[ch]) begin
               assert (channel_busy(ch))
               else abort_run($sformatf("ready on channel %0d with no outstanding request", ch));
               if (expect_read[ch]) begin
                  assert (dout[ch*data_width +: data_width] === expect_val[ch])
                  else abort_run($sformatf("MISMATCH test=%s channel=%0d expected=%02h actual=%02h",
                                           test_name, ch, expect_val[ch],
                                           dout[ch*data_width +: data_width]));
               end
               done_cnt[ch]++;
               order_q.push_back(ch);
            end
         end
      end
   end

   always @(posedge clock_bus) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
         abort_run($sformatf("timeout after %0d cycles, a request never completed", cycle_count));
      end
   end

   //========================================
   // Test sequence
   //========================================
   initial begin
      logic [addr_width-1:0] wr_addr [16];
      logic [addr_width-1:0] base;
      int                    first;
      bit                    more;
      rst_n = 1'b0;
      req   = '0;
      rnw   = '0;
      addr  = '0;
      din   = '0;
      repeat (5) @(posedge clock_bus);
      rst_n <= 1'b1;

      // No ready before the first request
      repeat (8) begin
         @(negedge clock_bus);
         assert (ready == '0) else abort_run("ready seen after reset with no request");
      end

      test_name = "write then read";
      for (int i = 0; i < 16; i++) begin
         wr_addr[i] = addr_width'(take_bits(addr_width));
         access(0, 1'b0, wr_addr[i], data_width'(take_bits(data_width)));
      end
      for (int i = 0; i < 16; i++) begin
         access(0, 1'b1, wr_addr[i], '0);
      end

      test_name = "cross channel";
      base = addr_width'(take_bits(addr_width));
      for (int i = 0; i < 8; i++) begin
         access(2, 1'b0, base + addr_width'(i), data_width'(take_bits(data_width)));
      end
      for (int i = 0; i < 8; i++) begin
         access(1, 1'b1, base + addr_width'(i), '0);
      end

      // All channels request in one cycle on an idle arbiter
      test_name = "priority order";
      wait_all_free();
      first = order_q.size();
      @(posedge clock_bus);
      for (int ch = 0; ch < num_channels; ch++) begin
         launch(ch, 1'b1, base + addr_width'(ch), '0);
      end
      push_inputs();
      wait_all_free();
      for (int i = 0; i < num_channels; i++) begin
         assert (order_q[first + i] == i)
         else abort_run($sformatf("MISMATCH test=%s expected=%0d actual=%0d",
                                  test_name, i, order_q[first + i]));
      end

      test_name = "concurrent traffic";
      for (int ch = 0; ch < num_channels; ch++) begin
         remaining[ch] = traffic_per_channel;
      end
      more = 1'b1;
      while (more) begin
         @(posedge clock_bus);
         more = 1'b0;
         for (int ch = 0; ch < num_channels; ch++) begin
            if (remaining[ch] > 0) begin
               more = 1'b1;
               if (!channel_busy(ch)) begin
                  issue_random(ch);
                  remaining[ch]--;
               end
            end
         end
         push_inputs();
      end
      wait_all_free();

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- mem_arbiter_top.f
hdl/mem_geometry_pkg.sv
hdl/mem_timing_pkg.sv
hdl/channel_slot.sv
hdl/priority_arbiter.sv
hdl/byte_ram.sv
hdl/mem_arbiter_top.sv
tb/mem_arbiter_tb.sv

//--- Makefile
# Verilator simulation of the multi-channel byte memory port

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = mem_arbiter_tb
FILELIST = mem_arbiter_top.f
LOG      = sim.log

.PHONY: sim clean

# Build, run, then look for the pass message in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
